// ==== hw/bpuPkg.sv ====
package bpuPkg;

    // kind of control transfer held in a table entry
    // brImme covers the conditional branches
    typedef enum logic [1:0] {
        brNone = 2'd0,
        brCall = 2'd1,
        brRetn = 2'd2,
        brImme = 2'd3
    } branchType;

    // two-bit saturating counter, ordered from strong not taken to strong taken
    // bit 1 set means predict taken
    typedef enum logic [1:0] {
        ctrStrongNt = 2'd0,
        ctrWeakNt   = 2'd1,
        ctrWeakT    = 2'd2,
        ctrStrongT  = 2'd3
    } counterState;

endpackage

// ==== hw/bhtRam.sv ====
`timescale 1ns/100ps

module bhtRam import bpuPkg::*; #(
    parameter int indexBits = 4,
    parameter int histBits  = 6
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  we,
    input  logic [histBits-1:0]   wrHistory,
    input  logic [31:0]           wrPc,
    input  logic [29-indexBits:0] wrTag,
    input  logic [31:0]           wrTarget,
    input  branchType             wrType,
    input  counterState           wrCount,
    input  logic [histBits-1:0]   rdHistory,
    input  logic [31:0]           rdPc,
    output logic [29-indexBits:0] rdTag,
    output logic [31:0]           rdTarget,
    output branchType             rdType,
    output counterState           rdCount
);

    localparam int addrBits = histBits + indexBits;
    localparam int depth    = 2 ** addrBits;

    logic [29-indexBits:0] tagMem    [depth];
    logic [31:0]           targetMem [depth];
    branchType             typeMem   [depth];
    counterState           countMem  [depth];

    logic [addrBits-1:0] wrAddr;
    logic [addrBits-1:0] rdAddr;

    // global history in the upper address bits, word index below
    assign wrAddr = {wrHistory, wrPc[indexBits+1:2]};
    assign rdAddr = {rdHistory, rdPc[indexBits+1:2]};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < depth; i++) begin
                tagMem[i]    <= '0;
                targetMem[i] <= '0;
                typeMem[i]   <= brNone;
                countMem[i]  <= ctrStrongNt;
            end
        end else if (we) begin
            tagMem[wrAddr]    <= wrTag;
            targetMem[wrAddr] <= wrTarget;
            typeMem[wrAddr]   <= wrType;
            countMem[wrAddr]  <= wrCount;
        end
    end

    // asynchronous read, a write at the same edge shows up one cycle later
    assign rdTag    = tagMem[rdAddr];
    assign rdTarget = targetMem[rdAddr];
    assign rdType   = typeMem[rdAddr];
    assign rdCount  = countMem[rdAddr];

endmodule

// ==== hw/globalHistory.sv ====
`timescale 1ns/100ps

module globalHistory #(
    parameter int histBits = 6
) (
    input  logic                clk,
    input  logic                arstN,
    input  logic                shiftEn,
    input  logic                outcome,
    output logic [histBits-1:0] history
);

    logic [histBits-1:0] histReg;
    logic [histBits-1:0] histNext;

    // newest outcome enters at bit 0, oldest falls off the top
    always_comb begin
        histNext = histReg;
        if (shiftEn) begin
            histNext = {histReg[histBits-2:0], outcome};
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            histReg <= '0;
        end else begin
            histReg <= histNext;
        end
    end

    assign history = histReg;

endmodule

// ==== hw/bhtUpdate.sv ====
`timescale 1ns/100ps

module bhtUpdate import bpuPkg::*; #(
    parameter int indexBits = 4
) (
    input  logic [31:0]           exePc,
    input  logic [31:0]           exeTarget,
    input  branchType             exeType,
    input  logic                  exeTaken,
    input  logic                  exeHit,
    input  counterState           exeCount,
    output logic [29-indexBits:0] wrTag,
    output logic [31:0]           wrTarget,
    output branchType             wrType,
    output counterState           wrCount
);

    // tag is whatever the index does not cover
    assign wrTag    = exePc[31:indexBits+2];
    assign wrTarget = exeTarget;
    assign wrType   = exeType;

    always_comb begin
        if (exeHit) begin
            // step one state toward the outcome, hold at both ends
            unique case (exeCount)
                ctrStrongT:  wrCount = exeTaken ? ctrStrongT : ctrWeakT;
                ctrWeakT:    wrCount = exeTaken ? ctrStrongT : ctrWeakNt;
                ctrWeakNt:   wrCount = exeTaken ? ctrWeakT   : ctrStrongNt;
                ctrStrongNt: wrCount = exeTaken ? ctrWeakNt  : ctrStrongNt;
                default:     wrCount = ctrStrongNt;
            endcase
        end else begin
            // fresh entry starts weak on the observed side
            wrCount = exeTaken ? ctrWeakT : ctrWeakNt;
        end
    end

endmodule

// ==== hw/predictStage.sv ====
`timescale 1ns/100ps

module predictStage import bpuPkg::*; #(
    parameter int indexBits = 4,
    parameter int histBits  = 6
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  fetchWr,
    input  logic                  fetchFlush,
    input  logic [31:0]           fetchPc,
    input  logic [29-indexBits:0] rdTag,
    input  logic [31:0]           rdTarget,
    input  branchType             rdType,
    input  counterState           rdCount,
    input  logic [histBits-1:0]   history,
    output logic [31:0]           predTarget,
    output logic                  predTaken,
    output branchType             predType,
    output counterState           predCount,
    output logic                  predHit,
    output logic                  predValid,
    output logic [histBits-1:0]   predHistory
);

    // captured table entry
    logic [29-indexBits:0] entryTag;
    logic [31:0]           entryTarget;
    branchType             entryType;
    counterState           entryCount;

    // captured fetch side
    logic [29-indexBits:0] pcTag;
    logic [31:0]           pcAdd8;
    logic [histBits-1:0]   histReg;
    logic                  validReg;

    logic hit;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            entryTag    <= '0;
            entryTarget <= '0;
            entryType   <= brNone;
            entryCount  <= ctrStrongNt;
            pcTag       <= '0;
            pcAdd8      <= 32'd8;
            histReg     <= '0;
            validReg    <= 1'b0;
        end else if (fetchFlush) begin
            // flush wins over a capture in the same cycle
            entryTag    <= '0;
            entryTarget <= '0;
            entryType   <= brNone;
            entryCount  <= ctrStrongNt;
            pcTag       <= '0;
            pcAdd8      <= 32'd8;
            histReg     <= '0;
            validReg    <= 1'b0;
        end else if (fetchWr) begin
            entryTag    <= rdTag;
            entryTarget <= rdTarget;
            entryType   <= rdType;
            entryCount  <= rdCount;
            pcTag       <= fetchPc[31:indexBits+2];
            pcAdd8      <= fetchPc + 32'd8;
            histReg     <= history;
            validReg    <= 1'b1;
        end
    end

    // a cleared register must not look like a hit on tag zero
    assign hit = validReg && (entryTag == pcTag);

    always_comb begin
        predTarget = pcAdd8;
        predTaken  = 1'b0;
        if (hit) begin
            unique case (entryType)
                brCall, brRetn: begin
                    // no return stack, returns reuse the stored target
                    predTarget = entryTarget;
                    predTaken  = 1'b1;
                end
                brImme: begin
                    if (entryCount[1]) begin
                        predTarget = entryTarget;
                        predTaken  = 1'b1;
                    end
                end
                default: begin
                    predTarget = pcAdd8;
                    predTaken  = 1'b0;
                end
            endcase
        end
    end

    assign predType    = hit ? entryType : brNone;
    assign predCount   = entryCount;
    assign predHit     = hit;
    assign predValid   = validReg;
    assign predHistory = histReg;

endmodule

// ==== hw/branchPredictor.sv ====
`timescale 1ns/100ps

module branchPredictor import bpuPkg::*; #(
    parameter int indexBits = 4,
    parameter int histBits  = 6
) (
    input  logic                clk,
    input  logic                arstN,
    // fetch side
    input  logic                fetchWr,
    input  logic                fetchFlush,
    input  logic [31:0]         fetchPc,
    output logic [31:0]         predTarget,
    output logic                predTaken,
    output branchType           predType,
    output counterState         predCount,
    output logic                predHit,
    output logic                predValid,
    output logic [histBits-1:0] predHistory,
    // resolved branch from execute
    input  logic                exeValid,
    input  logic [31:0]         exePc,
    input  logic [31:0]         exeTarget,
    input  branchType           exeType,
    input  logic                exeTaken,
    input  logic                exeHit,
    input  counterState         exeCount,
    input  logic [histBits-1:0] exeHistory
);

    logic [histBits-1:0]   history;
    logic                  shiftEn;

    logic [29-indexBits:0] wrTag;
    logic [31:0]           wrTarget;
    branchType             wrType;
    counterState           wrCount;

    logic [29-indexBits:0] rdTag;
    logic [31:0]           rdTarget;
    branchType             rdType;
    counterState           rdCount;

    // only conditional branches move the history
    assign shiftEn = exeValid && (exeType == brImme);

    globalHistory #(
        .histBits(histBits)
    ) uHistory (
        .clk     (clk),
        .arstN   (arstN),
        .shiftEn (shiftEn),
        .outcome (exeTaken),
        .history (history)
    );

    bhtUpdate #(
        .indexBits(indexBits)
    ) uUpdate (
        .exePc     (exePc),
        .exeTarget (exeTarget),
        .exeType   (exeType),
        .exeTaken  (exeTaken),
        .exeHit    (exeHit),
        .exeCount  (exeCount),
        .wrTag     (wrTag),
        .wrTarget  (wrTarget),
        .wrType    (wrType),
        .wrCount   (wrCount)
    );

    bhtRam #(
        .indexBits(indexBits),
        .histBits (histBits)
    ) uTable (
        .clk       (clk),
        .arstN     (arstN),
        .we        (exeValid),
        .wrHistory (exeHistory),
        .wrPc      (exePc),
        .wrTag     (wrTag),
        .wrTarget  (wrTarget),
        .wrType    (wrType),
        .wrCount   (wrCount),
        .rdHistory (history),
        .rdPc      (fetchPc),
        .rdTag     (rdTag),
        .rdTarget  (rdTarget),
        .rdType    (rdType),
        .rdCount   (rdCount)
    );

    predictStage #(
        .indexBits(indexBits),
        .histBits (histBits)
    ) uPredict (
        .clk         (clk),
        .arstN       (arstN),
        .fetchWr     (fetchWr),
        .fetchFlush  (fetchFlush),
        .fetchPc     (fetchPc),
        .rdTag       (rdTag),
        .rdTarget    (rdTarget),
        .rdType      (rdType),
        .rdCount     (rdCount),
        .history     (history),
        .predTarget  (predTarget),
        .predTaken   (predTaken),
        .predType    (predType),
        .predCount   (predCount),
        .predHit     (predHit),
        .predValid   (predValid),
        .predHistory (predHistory)
    );

endmodule

// ==== sim/branchPredictor_props.sv ====
`timescale 1ns/100ps

module branchPredictorProps import bpuPkg::*; (
    input logic      clk,
    input logic      arstN,
    input logic      fetchFlush,
    input logic      predValid,
    input logic      predTaken,
    input logic      predHit,
    input branchType predType
);

    // prediction register comes out of reset empty
    validAfterReset: assert property (@(posedge clk) !arstN |=> !predValid)
        else $error("predValid set in the cycle after reset");

    validAfterFlush: assert property (@(posedge clk) disable iff (!arstN)
        fetchFlush |=> !predValid)
        else $error("predValid set in the cycle after a flush");

    // a taken prediction always comes from a table hit
    takenNeedsHit: assert property (@(posedge clk) disable iff (!arstN)
        predTaken |-> predHit)
        else $error("predTaken without predHit");

    takenNeedsKind: assert property (@(posedge clk) disable iff (!arstN)
        predTaken |-> (predType != brNone))
        else $error("predTaken with branch kind none");

endmodule

bind branchPredictor branchPredictorProps uProps (.*);

// ==== sim/branchPredictorTb.sv ====
`timescale 1ns/100ps

module branchPredictorTb import bpuPkg::*; ();

    localparam int indexBits   = 4;
    localparam int histBits    = 6;
    localparam int depth       = 2 ** (histBits + indexBits);
    localparam int periodNs    = 20;
    localparam int resetCycles = 10;
    localparam int directedOps = 40;
    localparam int randomOps   = 200;

    typedef struct packed {
        logic [31:0]         target;
        logic                taken;
        branchType           kind;
        counterState         count;
        logic                hit;
        logic [histBits-1:0] hist;
    } predRec;

    logic                clk = 1'b0;
    logic                arstN = 1'b1;
    logic                fetchWr = 1'b0;
    logic                fetchFlush = 1'b0;
    logic [31:0]         fetchPc = '0;
    logic                exeValid = 1'b0;
    logic [31:0]         exePc = '0;
    logic [31:0]         exeTarget = '0;
    branchType           exeType = brNone;
    logic                exeTaken = 1'b0;
    logic                exeHit = 1'b0;
    counterState         exeCount = ctrStrongNt;
    logic [histBits-1:0] exeHistory = '0;
    logic [31:0]         predTarget;
    logic                predTaken;
    logic                predHit;
    logic                predValid;
    branchType           predType;
    counterState         predCount;
    logic [histBits-1:0] predHistory;

    // reference table, history and the predictions still to be compared
    logic [29-indexBits:0] mTag [depth];
    logic [31:0]           mTarget [depth];
    branchType             mType [depth];
    counterState           mCount [depth];
    logic [histBits-1:0]   mHist = '0;
    predRec                expQ [$];
    predRec                lastExp;
    string                 testName;
    int                    errCount = 0;
    int                    nChecks = 0;
    int                    testErrStart = 0;
    int                    testsRun = 0;
    int                    testsFailed = 0;
    int                    seed = 29;

    branchPredictor #(.indexBits(indexBits), .histBits(histBits)) UUT (.*);

    always #(periodNs / 2) clk = ~clk;

    function automatic logic [histBits-1:0] nextHist(input logic [histBits-1:0] h, input logic t);
        return {h[histBits-2:0], t};
    endfunction

    function automatic predRec predictRef(input logic [31:0] pc);
        predRec r;
        logic [histBits+indexBits-1:0] a;
        a = {mHist, pc[indexBits+1:2]};
        r.hit = (mTag[a] == pc[31:indexBits+2]);
        r.count = mCount[a];
        r.hist = mHist;
        r.kind = r.hit ? mType[a] : brNone;
        // calls and returns always go, conditionals only in the upper half of the counter
        r.taken = (r.kind == brCall) || (r.kind == brRetn) ||
                  (r.kind == brImme && r.count >= ctrWeakT);
        r.target = r.taken ? mTarget[a] : pc + 32'd8;
        return r;
    endfunction

    function automatic void updateRef(input logic [31:0] pc, input logic [31:0] target,
                                      input branchType kind, input logic taken, input logic hit,
                                      input counterState count, input logic [histBits-1:0] h);
        logic [histBits+indexBits-1:0] a;
        counterState c;
        a = {h, pc[indexBits+1:2]};
        if (!hit) begin
            c = taken ? ctrWeakT : ctrWeakNt;
        end else if (taken) begin
            c = (count == ctrStrongT) ? ctrStrongT : counterState'(count + 2'd1);
        end else begin
            c = (count == ctrStrongNt) ? ctrStrongNt : counterState'(count - 2'd1);
        end
        mTag[a] = pc[31:indexBits+2];
        mTarget[a] = target;
        mType[a] = kind;
        mCount[a] = c;
        if (kind == brImme) begin
            mHist = nextHist(mHist, taken);
        end
    endfunction

    task automatic checkWord(input string field, input logic [31:0] exp, input logic [31:0] act);
        nChecks++;
        if (act !== exp) begin
            errCount++;
            $display("Mismatch %s %s: expected %h, actual %h", testName, field, exp, act);
        end
    endtask

    task automatic checkBit(input string field, input logic exp, input logic act);
        nChecks++;
        if (act !== exp) begin
            errCount++;
            $display("Mismatch %s %s: expected %b, actual %b", testName, field, exp, act);
        end
    endtask

    task automatic checkType(input string field, input branchType exp, input branchType act);
        nChecks++;
        if (act !== exp) begin
            errCount++;
            $display("Mismatch %s %s: expected %s, actual %s", testName, field, exp.name(),
                     act.name());
        end
    endtask

    task automatic checkCount(input string field, input counterState exp, input counterState act);
        nChecks++;
        if (act !== exp) begin
            errCount++;
            $display("Mismatch %s %s: expected %s, actual %s", testName, field, exp.name(),
                     act.name());
        end
    endtask

    task automatic checkPred(input predRec e, input logic valid);
        checkWord("predTarget", e.target, predTarget);
        checkBit("predTaken", e.taken, predTaken);
        checkType("predType", e.kind, predType);
        checkCount("predCount", e.count, predCount);
        checkBit("predHit", e.hit, predHit);
        checkBit("predValid", valid, predValid);
        checkWord("predHistory", 32'(e.hist), 32'(predHistory));
    endtask

    task automatic fetch(input logic [31:0] pc);
        @(posedge clk);
        fetchWr <= 1'b1;
        fetchPc <= pc;
        expQ.push_back(predictRef(pc));
        @(posedge clk);
        fetchWr <= 1'b0;
        @(negedge clk);
    endtask

    task automatic update(input logic [31:0] pc, input logic [31:0] target, input branchType kind,
                          input logic taken, input logic hit, input counterState count,
                          input logic [histBits-1:0] h);
        @(posedge clk);
        exeValid <= 1'b1;
        exePc <= pc;
        exeTarget <= target;
        exeType <= kind;
        exeTaken <= taken;
        exeHit <= hit;
        exeCount <= count;
        exeHistory <= h;
        updateRef(pc, target, kind, taken, hit, count, h);
        @(posedge clk);
        exeValid <= 1'b0;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errCount == testErrStart) begin
            $display("test %s ok", testName);
        end else begin
            testsFailed++;
            $display("test %s failed with %0d errors", testName, errCount - testErrStart);
        end
        testErrStart = errCount;
    endtask

    // a captured fetch shows on the outputs during the following cycle
    always @(posedge clk) begin
        if (arstN && fetchWr && !fetchFlush) begin
            @(negedge clk);
            if (expQ.size() == 0) begin
                errCount++;
                $display("%s: the DUT captured a fetch that no test issued", testName);
            end else begin
                lastExp = expQ.pop_front();
                checkPred(lastExp, 1'b1);
            end
        end
    end

    // each operation takes at most four cycles
    initial begin
        #((resetCycles + 4 * (directedOps + randomOps)) * periodNs);
        $display("timeout: the tests did not finish in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] pc;
        logic [6:0]  outcomes;
        counterState stepExp [7];
        predRec      cleared;
        cleared = '0;
        cleared.target = 32'd8;
        for (int i = 0; i < depth; i++) begin
            mTag[i] = '0;
            mTarget[i] = '0;
            mType[i] = brNone;
            mCount[i] = ctrStrongNt;
        end
        @(posedge clk);
        arstN <= 1'b0;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);

        testName = "reset";
        checkPred(cleared, 1'b0);
        fetch(32'h0000_0100);
        fetch(32'h0000_1204);
        fetch(32'h0040_0ffc);
        fetch(32'hbfc0_0010);
        finishTest();

        // entry goes where the history will point after the shift
        testName = "taken";
        update(32'h0000_1040, 32'h0000_2000, brImme, 1'b1, 1'b0, ctrStrongNt,
               nextHist(mHist, 1'b1));
        fetch(32'h0000_1040);
        checkBit("predTaken", 1'b1, predTaken);
        checkBit("predHit", 1'b1, predHit);
        checkWord("predTarget", 32'h0000_2000, predTarget);
        checkCount("predCount", ctrWeakT, predCount);
        finishTest();

        testName = "counter";
        outcomes = 7'b1110000;
        stepExp = '{ctrWeakT, ctrStrongT, ctrStrongT, ctrWeakT, ctrWeakNt,
                    ctrStrongNt, ctrStrongNt};
        fetch(32'h0000_2010);
        for (int i = 0; i < 7; i++) begin
            update(32'h0000_2010, 32'h0000_2400, brImme, outcomes[6-i], predHit, predCount,
                   nextHist(predHistory, outcomes[6-i]));
            fetch(32'h0000_2010);
            checkCount("step", stepExp[i], predCount);
        end
        finishTest();

        testName = "callret";
        update(32'h0000_3008, 32'h0000_4000, brCall, 1'b1, 1'b0, ctrStrongNt, mHist);
        update(32'h0000_300c, 32'h0000_5000, brRetn, 1'b1, 1'b0, ctrStrongNt, mHist);
        fetch(32'h0000_3008);
        checkWord("callTarget", 32'h0000_4000, predTarget);
        fetch(32'h0000_300c);
        checkWord("retnTarget", 32'h0000_5000, predTarget);
        // same index as the call, tag one higher
        fetch(32'h0000_3048);
        checkBit("aliasHit", 1'b0, predHit);
        finishTest();

        testName = "flush";
        fetch(32'h0000_3008);
        @(posedge clk);
        fetchFlush <= 1'b1;
        fetchWr <= 1'b1;
        fetchPc <= 32'h0000_300c;
        @(posedge clk);
        fetchFlush <= 1'b0;
        fetchWr <= 1'b0;
        @(negedge clk);
        checkPred(cleared, 1'b0);
        fetch(32'h0000_300c);
        // outputs keep the last prediction while fetch is stalled
        repeat (3) begin
            @(posedge clk);
            fetchPc <= $random(seed);
            @(negedge clk);
            checkPred(lastExp, 1'b1);
        end
        finishTest();

        testName = "random";
        for (int n = 0; n < randomOps; n++) begin
            rnd = $random(seed);
            pc = 32'h0000_1000 | (rnd & 32'h0000_007c);
            if (rnd[8]) begin
                fetch(pc);
            end else begin
                update(pc, $random(seed) & 32'hffff_fffc, branchType'(rnd[10:9]), rnd[11],
                       rnd[12], counterState'(rnd[14:13]), mHist);
            end
        end
        finishTest();

        @(posedge clk);
        $display("%0d tests, %0d failed, %0d checks, %0d errors", testsRun, testsFailed,
                 nChecks, errCount);
        if (errCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/bpuPkg.sv
hw/bhtRam.sv
hw/globalHistory.sv
hw/bhtUpdate.sv
hw/predictStage.sv
hw/branchPredictor.sv
sim/branchPredictor_props.sv
sim/branchPredictorTb.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in its output
verilator --binary --timing --assert --timescale 1ns/100ps -f vlog.f \
    --top-module branchPredictorTb -Mdir obj_dir -o simv &&
    ./obj_dir/simv | tee /dev/stderr | grep -F "ALL TESTS PASSED" > /dev/null &&
    echo "run passed" ||
    { echo "run failed"; exit 1; }
